/* hw/riscv_pipe_settings.svh */
`ifndef RISCV_PIPE_SETTINGS_SVH
`define RISCV_PIPE_SETTINGS_SVH

// Data word width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Shift amount bits taken from operand B
`define SHAMT_W 5

`endif

/* hw/riscv_pipe_pkg.sv */
`include "riscv_pipe_settings.svh"

package riscv_pipe_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,	// R-type
		OPC_OP_IMM = 7'b0010011,	// I-type arithmetic
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLT    = 4'd2,
		ALU_SLTU   = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_OR     = 4'd5,
		ALU_AND    = 4'd6,
		ALU_SRL    = 4'd7,
		ALU_SLL    = 4'd8,
		ALU_SRA    = 4'd9,
		ALU_PASS_B = 4'd10	// LUI
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;	// Raw bits, may hold unknown encodings
	} instr_t;

	typedef struct packed {
		logic      valid;
		alu_op_e   alu_op;
		logic      use_imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
	} ex_ctrl_t;

	// Shared by the memory slot and writeback
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

/* hw/reg_file.sv */
`include "riscv_pipe_settings.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  riscv_pipe_pkg::reg_addr_t rs1,
	input  riscv_pipe_pkg::reg_addr_t rs2,
	output riscv_pipe_pkg::word_t   rs1_data,
	output riscv_pipe_pkg::word_t   rs2_data,
	input  riscv_pipe_pkg::wb_t     wb
);
	import riscv_pipe_pkg::*;

	word_t regs [`NUM_REGS];
	logic  wr_en;

	assign wr_en = wb.valid && (wb.rd != '0);	// x0 is never written

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Write-through so a same-cycle read sees the value being written
	assign rs1_data = (wr_en && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_data = (wr_en && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

/* hw/alu.sv */
`include "riscv_pipe_settings.svh"

module alu (
	input  riscv_pipe_pkg::word_t   a,
	input  riscv_pipe_pkg::word_t   b,
	input  riscv_pipe_pkg::alu_op_e op,
	output riscv_pipe_pkg::word_t   result
);
	import riscv_pipe_pkg::*;

	logic [`SHAMT_W-1:0] shamt;
	logic                lt_signed;
	logic                lt_unsigned;

	assign shamt       = b[`SHAMT_W-1:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLT:    result = word_t'(lt_signed);
			ALU_SLTU:   result = word_t'(lt_unsigned);
			ALU_XOR:    result = a ^ b;
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_SRL:    result = a >> shamt;
			ALU_SLL:    result = a << shamt;
			ALU_SRA:    result = word_t'($signed(a) >>> shamt);	// Sign fill
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

endmodule

/* hw/decode_stage.sv */
`include "riscv_pipe_settings.svh"

module decode_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     instr_valid,
	input  riscv_pipe_pkg::instr_t   instr,
	input  riscv_pipe_pkg::wb_t      wb,
	output riscv_pipe_pkg::ex_ctrl_t ex_ctrl
);
	import riscv_pipe_pkg::*;

	logic     fd_valid;
	instr_t   fd_instr;
	ex_ctrl_t dec;
	logic     legal;
	word_t    rs1_data;
	word_t    rs2_data;

	// alt selects SUB or SRA for the shared funct3 codes
	function automatic alu_op_e funct3_op(input logic [2:0] funct3, input logic alt);
		alu_op_e op;
		case (funct3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			fd_valid <= 1'b0;
		end else begin
			fd_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			fd_instr <= instr;
		end
	end

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rs1      (fd_instr.rs1),
		.rs2      (fd_instr.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	always_comb begin
		legal       = 1'b0;
		dec.use_imm = 1'b0;
		dec.alu_op  = ALU_ADD;
		dec.imm     = {{(`XLEN-12){fd_instr.funct7[6]}}, fd_instr.funct7, fd_instr.rs2};	// I-type
		case (opcode_e'(fd_instr.opcode))
			OPC_OP: begin
				legal = (fd_instr.funct7 == 7'b0000000) ||
					(fd_instr.funct7 == 7'b0100000 &&
					(fd_instr.funct3 == 3'b000 || fd_instr.funct3 == 3'b101));
				dec.alu_op = funct3_op(fd_instr.funct3, fd_instr.funct7[5]);
			end
			OPC_OP_IMM: begin
				dec.use_imm = 1'b1;
				case (fd_instr.funct3)
					3'b001:  legal = (fd_instr.funct7 == 7'b0000000);
					3'b101:  legal = (fd_instr.funct7 == 7'b0000000) ||
						(fd_instr.funct7 == 7'b0100000);
					default: legal = 1'b1;	// funct7 is immediate bits here
				endcase
				dec.alu_op = funct3_op(fd_instr.funct3,
					fd_instr.funct3 == 3'b101 && fd_instr.funct7[5]);
			end
			OPC_LUI: begin
				legal       = 1'b1;
				dec.use_imm = 1'b1;
				dec.alu_op  = ALU_PASS_B;
				dec.imm     = {fd_instr.funct7, fd_instr.rs2, fd_instr.rs1,
					fd_instr.funct3, 12'b0};
			end
			default: legal = 1'b0;	// Unknown opcode becomes a bubble
		endcase
		dec.valid    = fd_valid && legal;
		dec.rs1      = fd_instr.rs1;
		dec.rs2      = fd_instr.rs2;
		dec.rd       = fd_instr.rd;
		dec.rs1_data = rs1_data;
		dec.rs2_data = rs2_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_ctrl <= '0;
		end else begin
			ex_ctrl <= dec;
		end
	end

endmodule

/* hw/execute_stage.sv */
module execute_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  riscv_pipe_pkg::ex_ctrl_t ex_ctrl,
	output riscv_pipe_pkg::wb_t      mem_res,
	output riscv_pipe_pkg::wb_t      wb
);
	import riscv_pipe_pkg::*;

	word_t opnd_a;
	word_t rs2_fwd;
	word_t opnd_b;
	word_t alu_result;

	// Memory slot wins over writeback, x0 never forwards
	function automatic word_t forward(
		input reg_addr_t rs,
		input word_t     rf_data,
		input wb_t       mem_src,
		input wb_t       wb_src
	);
		word_t data;
		if (mem_src.valid && mem_src.rd != '0 && mem_src.rd == rs) begin
			data = mem_src.data;	// Distance 1
		end else if (wb_src.valid && wb_src.rd != '0 && wb_src.rd == rs) begin
			data = wb_src.data;	// Distance 2
		end else begin
			data = rf_data;
		end
		return data;
	endfunction

	assign opnd_a  = forward(ex_ctrl.rs1, ex_ctrl.rs1_data, mem_res, wb);
	assign rs2_fwd = forward(ex_ctrl.rs2, ex_ctrl.rs2_data, mem_res, wb);
	assign opnd_b  = ex_ctrl.use_imm ? ex_ctrl.imm : rs2_fwd;

	alu u_alu (
		.a      (opnd_a),
		.b      (opnd_b),
		.op     (ex_ctrl.alu_op),
		.result (alu_result)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_res <= '0;
		end else begin
			mem_res.valid <= ex_ctrl.valid;
			mem_res.rd    <= ex_ctrl.rd;
			mem_res.data  <= alu_result;
		end
	end

	// Empty memory slot, result moves straight on
	always_ff @(posedge clk) begin
		if (reset) begin
			wb <= '0;
		end else begin
			wb <= mem_res;
		end
	end

endmodule

/* hw/riscv_pipe.sv */
module riscv_pipe (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   instr_valid,
	input  riscv_pipe_pkg::instr_t instr,
	output riscv_pipe_pkg::wb_t    wb
);
	import riscv_pipe_pkg::*;

	ex_ctrl_t ex_ctrl;
	wb_t      mem_res;

	decode_stage u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),	// Register file write port
		.ex_ctrl     (ex_ctrl)
	);

	execute_stage u_execute (
		.clk     (clk),
		.reset   (reset),
		.ex_ctrl (ex_ctrl),
		.mem_res (mem_res),
		.wb      (wb)
	);

endmodule

/* tests/riscv_pipe_assertions.sv */
module riscv_pipe_assertions (
	input logic                clk,
	input logic                reset,
	input logic                instr_valid,
	input riscv_pipe_pkg::wb_t wb
);
	timeunit 1ns;
	timeprecision 1ps;
	import riscv_pipe_pkg::*;

	int assert_errors = 0;

	// Fixed latency of four sampled edges
	property retire_after_issue;
		@(posedge clk) disable iff (reset) wb.valid |-> $past(instr_valid, 4);
	endproperty

	property quiet_in_reset;
		@(posedge clk) reset |=> !wb.valid [*2];	// Covers the cycle after reset too
	endproperty

	property known_when_valid;
		@(posedge clk) disable iff (reset) wb.valid |-> !$isunknown(wb);
	endproperty

	assert property (retire_after_issue) else begin
		assert_errors++;
		$error("wb.valid without an instruction 4 edges back");
	end
	assert property (quiet_in_reset) else begin
		assert_errors++;
		$error("wb.valid high during or just after reset");
	end
	assert property (known_when_valid) else begin
		assert_errors++;
		$error("wb holds X or Z bits while valid");
	end

endmodule

bind riscv_pipe riscv_pipe_assertions u_assertions (
	.clk         (clk),
	.reset       (reset),
	.instr_valid (instr_valid),
	.wb          (wb)
);

/* tests/riscv_pipe_tb.sv */
module riscv_pipe_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import riscv_pipe_pkg::*;

	localparam int num_random = 400;
	localparam int timeout_cycles = num_random * 4 + 400;	// Worst gaps plus reset and directed

	logic        clk;
	logic        reset;
	logic        instr_valid;
	instr_t      instr;
	wb_t         wb;
	word_t       ref_regs [32];
	wb_t         exp_q [$];
	int          issue_q [$];
	logic [31:0] lfsr_state;
	int          cycle = 0;
	int          data_errors = 0;
	int          latency_errors = 0;
	int          other_errors = 0;

	riscv_pipe u_riscv_pipe (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	// ISA semantics over the sequential register model
	function automatic wb_t ref_result(input instr_t ins, output logic legal);
		wb_t   r;
		word_t a;
		word_t b;
		word_t sra;
		logic  alt;
		a = ref_regs[ins.rs1];
		b = ref_regs[ins.rs2];
		alt = 1'b0;
		legal = 1'b0;
		case (ins.opcode)
			OPC_OP: begin
				legal = ins.funct7 == 7'h00 ||
					(ins.funct7 == 7'h20 && (ins.funct3 == 3'b000 || ins.funct3 == 3'b101));
				alt = ins.funct7[5];
			end
			OPC_OP_IMM: begin
				if (ins.funct3 == 3'b001) legal = ins.funct7 == 7'h00;
				else if (ins.funct3 == 3'b101) legal = ins.funct7 == 7'h00 || ins.funct7 == 7'h20;
				else legal = 1'b1;
				alt = ins.funct3 == 3'b101 && ins.funct7[5];
				b = {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
			end
			OPC_LUI: legal = 1'b1;
			default: legal = 1'b0;
		endcase
		sra = $signed(a) >>> b[4:0];
		r.valid = 1'b1;
		r.rd = ins.rd;
		if (ins.opcode == OPC_LUI) begin
			r.data = {ins[31:12], 12'b0};
		end else begin
			case (ins.funct3)
				3'b000:  r.data = alt ? a - b : a + b;
				3'b001:  r.data = a << b[4:0];
				3'b010:  r.data = {31'b0, $signed(a) < $signed(b)};
				3'b011:  r.data = {31'b0, a < b};
				3'b100:  r.data = a ^ b;
				3'b101:  r.data = alt ? sra : a >> b[4:0];
				3'b110:  r.data = a | b;
				default: r.data = a & b;
			endcase
		end
		return r;
	endfunction

	// Called at a falling edge, returns at a falling edge
	task automatic drive_instr(input instr_t ins, input int gap);
		wb_t  exp;
		logic legal;
		exp = ref_result(ins, legal);
		instr_valid = 1'b1;
		instr = ins;
		if (legal) begin
			exp_q.push_back(exp);
			issue_q.push_back(cycle);
			if (ins.rd != '0) ref_regs[ins.rd] = exp.data;
		end
		@(negedge clk);
		if (gap > 0) begin
			instr_valid = 1'b0;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic r_type(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2, input int gap);
		drive_instr(instr_t'({f7, rs2, rs1, f3, rd, OPC_OP}), gap);
	endtask

	task automatic i_type(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
			input logic [11:0] imm, input int gap);
		drive_instr(instr_t'({imm, rs1, f3, rd, OPC_OP_IMM}), gap);
	endtask

	task automatic load_upper(input reg_addr_t rd, input logic [19:0] imm, input int gap);
		drive_instr(instr_t'({imm, rd, OPC_LUI}), gap);
	endtask

	task automatic random_stream(input int count);
		logic [2:0]  kind;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic        alt;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		int          gap;
		for (int i = 0; i < count; i++) begin
			kind = 3'(take_bits(3));
			f3 = 3'(take_bits(3));
			rd = reg_addr_t'(take_bits(3));	// x0 to x7 keeps hazards frequent
			rs1 = reg_addr_t'(take_bits(3));
			rs2 = reg_addr_t'(take_bits(3));
			alt = 1'(take_bits(1));
			gap = take_bits(2);
			if (kind < 4) begin
				r_type({1'b0, alt, 5'b0}, f3, rd, rs1, rs2, gap);
			end else if (kind < 7) begin
				imm = 12'(take_bits(12));
				if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = {1'b0, alt, 5'b0};
				i_type(f3, rd, rs1, imm, gap);
			end else begin
				load_upper(rd, 20'(take_bits(20)), gap);
			end
		end
	endtask

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got.rd !== exp.rd) begin
			data_errors++;
			$display("Mismatch at %0t: wb.rd got %0d expected %0d", $time, got.rd, exp.rd);
		end
		if (got.data !== exp.data) begin
			data_errors++;
			$display("Mismatch at %0t: wb.data got %h expected %h", $time, got.data, exp.data);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			latency_errors++;
			$display("Mismatch at %0t: latency got %0d expected %0d", $time, got, exp);
		end
	endtask

	always @(negedge clk) begin
		if (wb.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("Unexpected writeback strobe at %0t with nothing in flight", $time);
			end else begin
				check_wb(wb, exp_q.pop_front());
				check_latency(cycle - issue_q.pop_front(), 4);
			end
		end
	end

	initial begin
		wait (cycle >= timeout_cycles);
		$display("Timeout after %0d cycles, the run did not finish", cycle);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		lfsr_state = 32'h6f57073b;
		foreach (ref_regs[i]) begin
			ref_regs[i] = '0;
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		r_type(7'h00, 3'b110, 5'd4, 5'd6, 5'd7, 3);	// Registers still at reset zero
		load_upper(5'd1, 20'h80000, 0);
		i_type(3'b000, 5'd1, 5'd1, 12'h005, 3);
		i_type(3'b000, 5'd2, 5'd0, 12'hffd, 3);	// x2 = -3
		i_type(3'b000, 5'd3, 5'd0, 12'h007, 3);
		for (int f = 0; f < 8; f++) begin
			r_type(7'h00, 3'(f), 5'd4, 5'd1, 5'd2, 3);
		end
		r_type(7'h20, 3'b000, 5'd5, 5'd2, 5'd1, 3);
		r_type(7'h20, 3'b101, 5'd5, 5'd1, 5'd3, 3);
		r_type(7'h00, 3'b010, 5'd6, 5'd2, 5'd3, 3);
		r_type(7'h00, 3'b011, 5'd6, 5'd2, 5'd3, 3);
		for (int f = 0; f < 8; f++) begin
			if (f != 1 && f != 5) i_type(3'(f), 5'd4, 5'd1, 12'hf9c, 3);
		end
		i_type(3'b001, 5'd5, 5'd1, 12'h004, 3);
		i_type(3'b101, 5'd5, 5'd1, 12'h01f, 3);
		i_type(3'b101, 5'd5, 5'd1, 12'h41f, 3);	// SRAI by 31
		load_upper(5'd7, 20'hfedcb, 3);
		i_type(3'b000, 5'd1, 5'd0, 12'h123, 0);
		r_type(7'h00, 3'b000, 5'd2, 5'd1, 5'd1, 0);
		i_type(3'b100, 5'd3, 5'd1, 12'h0ff, 0);
		r_type(7'h00, 3'b110, 5'd4, 5'd1, 5'd2, 0);
		r_type(7'h20, 3'b000, 5'd5, 5'd4, 5'd3, 0);
		r_type(7'h20, 3'b101, 5'd6, 5'd5, 5'd4, 0);
		r_type(7'h00, 3'b011, 5'd7, 5'd6, 5'd1, 0);
		i_type(3'b000, 5'd1, 5'd0, 12'h001, 0);
		i_type(3'b000, 5'd1, 5'd0, 12'h002, 0);	// Youngest write must win
		r_type(7'h00, 3'b000, 5'd2, 5'd1, 5'd1, 3);
		i_type(3'b000, 5'd0, 5'd0, 12'h155, 0);
		r_type(7'h00, 3'b000, 5'd1, 5'd0, 5'd0, 0);
		i_type(3'b000, 5'd2, 5'd0, 12'h001, 3);
		i_type(3'b000, 5'd1, 5'd0, 12'h5a5, 0);
		r_type(7'h01, 3'b000, 5'd1, 5'd2, 5'd3, 0);
		r_type(7'h20, 3'b001, 5'd1, 5'd2, 5'd3, 0);
		i_type(3'b001, 5'd1, 5'd2, 12'h401, 0);
		i_type(3'b101, 5'd1, 5'd2, 12'h021, 0);
		drive_instr(instr_t'({7'h00, 5'd2, 5'd1, 3'b000, 5'd1, 7'b0000011}), 0);
		r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd0, 3);
		random_stream(num_random);
		instr_valid = 1'b0;
		for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected writebacks never arrived", exp_q.size());
		end
		$display("Errors: data %0d, latency %0d, other %0d, assertion %0d",
			data_errors, latency_errors, other_errors,
			u_riscv_pipe.u_assertions.assert_errors);
		if (data_errors + latency_errors + other_errors +
				u_riscv_pipe.u_assertions.assert_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* riscv_pipe.f */
+incdir+hw
hw/riscv_pipe_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/riscv_pipe.sv
tests/riscv_pipe_assertions.sv
tests/riscv_pipe_tb.sv
